// File: sources.f
eforth1_pkg.sv
mem_io.sv
stack_ram.sv
stack_arb.sv
stack_ctl.sv
stack_unit.sv
tb_clock.sv
tb_stack_unit.sv

// File: Makefile
# Verilator build and run of the stack unit testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_stack_unit
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= TESTS FAILED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_stack_unit.sv
// testbench for the forth stack unit
// directed and random push/pop traffic on both stacks, checked against queue models
// per-stack checker holds the model and the concurrent assertions
`timescale 1ns/10ps
`default_nettype none

module stack_check #(
    parameter int    DEPTH   = 16,
    parameter int    DSZ     = eforth1_pkg::DSZ,
    parameter int    MAX_LAT = 4,                // strobe to done, worst case
    parameter string NAME    = "ds"
) (
    input  wire logic                   ss_if,
    input  wire logic                   rst,
    input  wire logic                   en,
    input  wire eforth1_pkg::ss_op_e    op,
    input  wire logic [DSZ-1:0]         t,
    input  wire logic [DSZ-1:0]         s,
    input  wire logic                   busy,
    input  wire logic                   done,
    input  wire logic                   overflow,
    input  wire logic                   underflow,
    input  wire logic [$clog2(DEPTH):0] depth,
    output int                          errs
);

    localparam int CW = $clog2(DEPTH) + 1;

    logic [DSZ-1:0] q [$];                       // model stack, top at the back
    logic [DSZ-1:0] exp_s;
    logic [CW-1:0]  exp_depth;
    logic           exp_ovf;
    logic           exp_unf;
    logic           acc;                         // strobe taken by the DUT
    logic           pend;                        // op in flight
    logic           settled;                     // outputs must match the model
    int             lat;                         // cycles since the strobe

    assign acc     = en && !pend && (op != eforth1_pkg::SS_NONE);
    assign settled = !busy || done;

    initial errs = 0;

    // reference model, advanced once per accepted strobe
    always @(posedge ss_if) begin
        if (rst) begin
            q.delete();
            exp_s     <= '0;
            exp_depth <= '0;
            exp_ovf   <= 1'b0;
            exp_unf   <= 1'b0;
        end else if (acc) begin
            if (op == eforth1_pkg::SS_PUSH) begin
                if (q.size() == DEPTH) begin
                    exp_ovf <= 1'b1;             // full, memory untouched
                end else begin
                    q.push_back(t);
                end
            end else if (q.size() == 0) begin
                exp_unf <= 1'b1;                 // empty, s keeps its value
            end else begin
                exp_s <= q.pop_back();
            end
            exp_depth <= CW'(q.size());
        end
    end

    // outstanding op tracker for busy, done and latency
    always @(posedge ss_if) begin
        if (rst) begin
            pend <= 1'b0;
            lat  <= 0;
        end else if (acc) begin
            pend <= 1'b1;
            lat  <= 1;
        end else if (done) begin
            pend <= 1'b0;
            lat  <= 0;
        end else if (pend) begin
            lat <= lat + 1;
        end
    end

    a_s: assert property (@(posedge ss_if) disable iff (rst) settled |-> s == exp_s)
        else begin
            errs = errs + 1;
            $display("ERROR t=%0t %s_s expected %h got %h",
                     $time, NAME, $sampled(exp_s), $sampled(s));
        end

    a_depth: assert property (@(posedge ss_if) disable iff (rst)
        settled |-> depth == exp_depth)
        else begin
            errs = errs + 1;
            $display("ERROR t=%0t %s_depth expected %0d got %0d",
                     $time, NAME, $sampled(exp_depth), $sampled(depth));
        end

    a_ovf: assert property (@(posedge ss_if) disable iff (rst)
        settled |-> overflow == exp_ovf)
        else begin
            errs = errs + 1;
            $display("ERROR t=%0t %s_overflow expected %b got %b",
                     $time, NAME, $sampled(exp_ovf), $sampled(overflow));
        end

    a_unf: assert property (@(posedge ss_if) disable iff (rst)
        settled |-> underflow == exp_unf)
        else begin
            errs = errs + 1;
            $display("ERROR t=%0t %s_underflow expected %b got %b",
                     $time, NAME, $sampled(exp_unf), $sampled(underflow));
        end

    // busy from the cycle after the strobe up to and including done
    a_busy: assert property (@(posedge ss_if) disable iff (rst) busy == pend)
        else begin
            errs = errs + 1;
            $display("ERROR t=%0t %s_busy expected %b got %b",
                     $time, NAME, $sampled(pend), $sampled(busy));
        end

    a_done: assert property (@(posedge ss_if) disable iff (rst) done |-> pend)
        else begin
            errs = errs + 1;
            $display("t=%0t %s_done pulsed with no accepted strobe pending", $time, NAME);
        end

    a_lat: assert property (@(posedge ss_if) disable iff (rst) pend |-> lat <= MAX_LAT)
        else begin
            errs = errs + 1;
            $display("t=%0t %s operation still not done %0d cycles after its strobe",
                     $time, NAME, $sampled(lat));
        end

endmodule : stack_check

module tb_stack_unit;

    localparam int DEPTH      = 16;
    localparam int DSZ        = eforth1_pkg::DSZ;
    localparam int DW         = $clog2(DEPTH) + 1;
    localparam int RST_CYCLES = 16;
    localparam int RAND_OPS   = 240;
    localparam int OP_BUDGET  = 300;                 // directed plus random ops
    // an op needs 2 drive cycles, up to 4 of latency and an idle check, 12 leaves slack
    localparam int CYC_LIMIT  = RST_CYCLES + OP_BUDGET * 12 + 400;

    logic                ss_if;
    logic                rst;
    logic                en;
    eforth1_pkg::ss_op_e ds_op;
    eforth1_pkg::ss_op_e rs_op;
    logic [DSZ-1:0]      ds_t;
    logic [DSZ-1:0]      rs_t;
    logic [DSZ-1:0]      ds_s;
    logic [DSZ-1:0]      rs_s;
    logic                ds_busy;
    logic                rs_busy;
    logic                ds_done;
    logic                rs_done;
    logic                ds_overflow;
    logic                rs_overflow;
    logic                ds_underflow;
    logic                rs_underflow;
    logic [DW-1:0]       ds_depth;
    logic [DW-1:0]       rs_depth;
    int                  ds_errs;
    int                  rs_errs;
    int                  cycles = 0;
    integer              seed;
    logic [31:0]         rnd;
    logic [31:0]         rnd2;

    tb_clock #(.PERIOD_NS(40)) clk_i (.ss_if(ss_if));

    stack_unit #(.DEPTH(DEPTH), .DSZ(DSZ)) dut_i (
        .ss_if(ss_if), .rst(rst), .en(en),
        .ds_op(ds_op), .ds_t(ds_t), .rs_op(rs_op), .rs_t(rs_t),
        .ds_s(ds_s), .rs_s(rs_s),
        .ds_busy(ds_busy), .rs_busy(rs_busy),
        .ds_done(ds_done), .rs_done(rs_done),
        .ds_overflow(ds_overflow), .rs_overflow(rs_overflow),
        .ds_underflow(ds_underflow), .rs_underflow(rs_underflow),
        .ds_depth(ds_depth), .rs_depth(rs_depth)
    );

    stack_check #(.DEPTH(DEPTH), .DSZ(DSZ), .NAME("ds")) ds_chk_i (
        .ss_if(ss_if), .rst(rst), .en(en), .op(ds_op), .t(ds_t), .s(ds_s),
        .busy(ds_busy), .done(ds_done), .overflow(ds_overflow),
        .underflow(ds_underflow), .depth(ds_depth), .errs(ds_errs)
    );

    stack_check #(.DEPTH(DEPTH), .DSZ(DSZ), .NAME("rs")) rs_chk_i (
        .ss_if(ss_if), .rst(rst), .en(en), .op(rs_op), .t(rs_t), .s(rs_s),
        .busy(rs_busy), .done(rs_done), .overflow(rs_overflow),
        .underflow(rs_underflow), .depth(rs_depth), .errs(rs_errs)
    );

    // random op, code 2 steers toward half full
    function automatic eforth1_pkg::ss_op_e pick_op(input logic [1:0] code,
                                                    input logic [DW-1:0] depth);
        case (code)
            2'd0:    pick_op = eforth1_pkg::SS_PUSH;
            2'd1:    pick_op = eforth1_pkg::SS_POP;
            2'd2:    pick_op = (depth < DW'(DEPTH / 2)) ? eforth1_pkg::SS_PUSH
                                                        : eforth1_pkg::SS_POP;
            default: pick_op = eforth1_pkg::SS_NONE;
        endcase
    endfunction

    // sampled at the falling edge, away from the drive edge
    task automatic wait_idle();
        do begin
            @(negedge ss_if);
        end while (ds_busy || rs_busy);
    endtask

    // one strobe cycle on both stacks, then wait for both to finish
    task automatic drive_ops(input eforth1_pkg::ss_op_e d_op, input logic [DSZ-1:0] d_val,
                             input eforth1_pkg::ss_op_e r_op, input logic [DSZ-1:0] r_val);
        @(posedge ss_if);
        ds_op <= d_op;
        ds_t  <= d_val;
        rs_op <= r_op;
        rs_t  <= r_val;
        @(posedge ss_if);                        // strobe captured here
        ds_op <= eforth1_pkg::SS_NONE;
        rs_op <= eforth1_pkg::SS_NONE;
        wait_idle();
    endtask

    initial begin
        rst   = 1'b1;
        en    = 1'b0;
        ds_op = eforth1_pkg::SS_NONE;
        rs_op = eforth1_pkg::SS_NONE;
        ds_t  = '0;
        rs_t  = '0;
        seed  = 15;
        repeat (RST_CYCLES) @(posedge ss_if);
        rst <= 1'b0;
        en  <= 1'b1;

        // data stack order, ten in and ten back out
        for (int i = 0; i < 10; i++) begin
            drive_ops(eforth1_pkg::SS_PUSH, DSZ'(32'h1000 + i * 291), eforth1_pkg::SS_NONE, '0);
        end
        for (int i = 0; i < 10; i++) begin
            drive_ops(eforth1_pkg::SS_POP, '0, eforth1_pkg::SS_NONE, '0);
        end

        // fill, one push too many, then the top must still be the 16th value
        for (int i = 0; i < DEPTH; i++) begin
            drive_ops(eforth1_pkg::SS_PUSH, DSZ'(32'h5000 + i), eforth1_pkg::SS_NONE, '0);
        end
        drive_ops(eforth1_pkg::SS_PUSH, 16'h5fff, eforth1_pkg::SS_NONE, '0);
        for (int i = 0; i < DEPTH; i++) begin
            drive_ops(eforth1_pkg::SS_POP, '0, eforth1_pkg::SS_NONE, '0);
        end

        // both stacks empty now
        drive_ops(eforth1_pkg::SS_POP, '0, eforth1_pkg::SS_POP, '0);

        // strobes with en low are ignored
        drive_ops(eforth1_pkg::SS_PUSH, 16'hbeef, eforth1_pkg::SS_NONE, '0);
        @(posedge ss_if);
        en    <= 1'b0;
        ds_op <= eforth1_pkg::SS_PUSH;
        ds_t  <= 16'h0bad;
        rs_op <= eforth1_pkg::SS_PUSH;
        rs_t  <= 16'h0bad;
        repeat (3) @(posedge ss_if);
        en    <= 1'b1;
        ds_op <= eforth1_pkg::SS_NONE;
        rs_op <= eforth1_pkg::SS_NONE;
        wait_idle();

        // push held during a pop, seen only while busy
        @(posedge ss_if);
        ds_op <= eforth1_pkg::SS_POP;
        @(posedge ss_if);                        // pop taken
        ds_op <= eforth1_pkg::SS_PUSH;
        ds_t  <= 16'hdead;
        repeat (2) @(posedge ss_if);
        ds_op <= eforth1_pkg::SS_NONE;
        wait_idle();

        // random traffic, both stacks strobed together
        for (int n = 0; n < RAND_OPS; n++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            drive_ops(pick_op(rnd[1:0], ds_depth), rnd[31:16],
                      pick_op(rnd[3:2], rs_depth), rnd2[15:0]);
        end

        repeat (2) @(posedge ss_if);             // let the last checks fire
        @(negedge ss_if);
        $display("error count: data stack %0d, return stack %0d", ds_errs, rs_errs);
        if (ds_errs + rs_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog on total run length
    always @(posedge ss_if) begin
        cycles <= cycles + 1;
        if (cycles == CYC_LIMIT) begin
            $display("run timed out after %0d cycles before the tests finished", CYC_LIMIT);
            $display("error count: data stack %0d, return stack %0d", ds_errs, rs_errs);
            $display("TESTS FAILED");
            $finish;
        end
    end

endmodule : tb_stack_unit

`default_nettype wire

// File: tb_clock.sv
// testbench clock source for the stack unit
// free running, 40 ns period by default
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 40                 // full clock period
) (
    output logic ss_if
);

    initial begin
        ss_if = 1'b0;
        forever #(PERIOD_NS / 2) ss_if = ~ss_if; // half period high, half low
    end

endmodule : tb_clock

`default_nettype wire

// File: stack_unit.sv
// forth stack unit, data stack plus return stack
// two controllers share one RAM through a round-robin arbiter
// data stack in the low half of the RAM, return stack in the high half
`timescale 1ns/10ps
`default_nettype none

module stack_unit #(
    parameter int DEPTH = 16,                    // words per stack
    parameter int DSZ   = eforth1_pkg::DSZ       // word width
) (
    input  wire logic                 ss_if,     // clock
    input  wire logic                 rst,       // sync reset, active high
    input  wire logic                 en,        // global strobe enable
    input  wire eforth1_pkg::ss_op_e  ds_op,
    input  wire logic [DSZ-1:0]       ds_t,
    input  wire eforth1_pkg::ss_op_e  rs_op,
    input  wire logic [DSZ-1:0]       rs_t,
    output logic [DSZ-1:0]            ds_s,
    output logic [DSZ-1:0]            rs_s,
    output logic                      ds_busy,
    output logic                      rs_busy,
    output logic                      ds_done,
    output logic                      rs_done,
    output logic                      ds_overflow,
    output logic                      rs_overflow,
    output logic                      ds_underflow,
    output logic                      rs_underflow,
    output logic [$clog2(DEPTH):0]    ds_depth,
    output logic [$clog2(DEPTH):0]    rs_depth
);

    localparam int AW = $clog2(2 * DEPTH);       // covers both stack regions

    logic           ram_en;
    logic           ram_we;
    logic [AW-1:0]  ram_addr;
    logic [DSZ-1:0] ram_wdata;
    logic [DSZ-1:0] ram_rdata;

    mem_io #(.AW(AW), .DSZ(DSZ)) ds_bus ();
    mem_io #(.AW(AW), .DSZ(DSZ)) rs_bus ();

    stack_ctl #(.DEPTH(DEPTH), .DSZ(DSZ), .AW(AW), .BASE(0)) ds_ctl_i (
        .ss_if     (ss_if),
        .rst       (rst),
        .en        (en),
        .op        (ds_op),
        .t         (ds_t),
        .bus       (ds_bus),
        .s         (ds_s),
        .busy      (ds_busy),
        .done      (ds_done),
        .overflow  (ds_overflow),
        .underflow (ds_underflow),
        .depth     (ds_depth)
    );

    stack_ctl #(.DEPTH(DEPTH), .DSZ(DSZ), .AW(AW), .BASE(DEPTH)) rs_ctl_i (
        .ss_if     (ss_if),
        .rst       (rst),
        .en        (en),
        .op        (rs_op),
        .t         (rs_t),
        .bus       (rs_bus),
        .s         (rs_s),
        .busy      (rs_busy),
        .done      (rs_done),
        .overflow  (rs_overflow),
        .underflow (rs_underflow),
        .depth     (rs_depth)
    );

    stack_arb #(.DSZ(DSZ), .AW(AW)) arb_i (
        .ss_if     (ss_if),
        .rst       (rst),
        .ds        (ds_bus),
        .rs        (rs_bus),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    stack_ram #(.DSZ(DSZ), .AW(AW)) ram_i (
        .ss_if (ss_if),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule : stack_unit

`default_nettype wire

// File: stack_ctl.sv
// single stack controller
// keeps count and sticky error flags, sequences push/pop through the RAM arbiter
// top of stack lives at BASE + count - 1
`timescale 1ns/10ps
`default_nettype none

module stack_ctl #(
    parameter int DEPTH = 16,                    // words in this stack
    parameter int DSZ   = eforth1_pkg::DSZ,      // word width
    parameter int AW    = 5,                     // RAM address width
    parameter int BASE  = 0                      // first RAM word of this stack
) (
    input  wire logic                   ss_if,   // clock
    input  wire logic                   rst,     // sync reset, active high
    input  wire logic                   en,      // global strobe enable
    input  wire eforth1_pkg::ss_op_e    op,      // requested operation
    input  wire logic [DSZ-1:0]         t,       // value to push
    mem_io.mst                          bus,     // request channel to arbiter
    output logic [DSZ-1:0]              s,       // last popped value
    output logic                        busy,
    output logic                        done,
    output logic                        overflow,   // sticky, push when full
    output logic                        underflow,  // sticky, pop when empty
    output logic [$clog2(DEPTH):0]      depth       // entries held
);

    localparam int CW = $clog2(DEPTH) + 1;       // count width, holds 0..DEPTH

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,                         // waiting for a strobe
        ST_REQ   = 2'd1,                         // req up, waiting for gnt
        ST_RWAIT = 2'd2,                         // RAM read data in flight
        ST_FIN   = 2'd3                          // done pulse
    } ctl_state_e;

    ctl_state_e           state;
    eforth1_pkg::ss_op_e  op_q;                  // operation held for the sequence
    logic [CW-1:0]        count;
    logic [CW-1:0]        ptr;                   // stack slot touched by op_q
    logic [DSZ-1:0]       t_q;                   // push payload
    logic                 strobe;
    logic                 full;
    logic                 empty;

    // a strobe only counts while idle and enabled
    assign strobe = en && (state == ST_IDLE) && (op != eforth1_pkg::SS_NONE);
    assign full   = (count == CW'(DEPTH));
    assign empty  = (count == '0);

    // push goes one above top, pop reads the top
    assign ptr = (op_q == eforth1_pkg::SS_PUSH) ? count : count - 1'b1;

    assign bus.req   = (state == ST_REQ);
    assign bus.we    = (op_q == eforth1_pkg::SS_PUSH);
    assign bus.addr  = AW'(BASE) + AW'(ptr);     // offset into this stack's half
    assign bus.wdata = t_q;

    assign busy  = (state != ST_IDLE);           // strobe cycle excluded, done cycle included
    assign done  = (state == ST_FIN);
    assign depth = count;

    always_ff @(posedge ss_if) begin
        if (rst) begin
            state     <= ST_IDLE;
            op_q      <= eforth1_pkg::SS_NONE;
            count     <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
            s         <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (strobe) begin
                        op_q <= op;
                        if (op == eforth1_pkg::SS_PUSH && full) begin
                            overflow <= 1'b1;            // no RAM access
                            state    <= ST_FIN;
                        end else if (op != eforth1_pkg::SS_PUSH && empty) begin
                            underflow <= 1'b1;           // s left as is
                            state     <= ST_FIN;
                        end else begin
                            state <= ST_REQ;
                        end
                    end
                end
                ST_REQ: begin
                    if (bus.gnt) begin
                        if (op_q == eforth1_pkg::SS_PUSH) begin
                            count <= count + 1'b1;       // RAM writes on this edge
                            state <= ST_FIN;
                        end else begin
                            count <= count - 1'b1;
                            state <= ST_RWAIT;           // RAM registers read data
                        end
                    end
                end
                ST_RWAIT: begin
                    s     <= bus.rdata;                  // only valid here
                    state <= ST_FIN;
                end
                ST_FIN: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // payload only sampled on a strobe
    always_ff @(posedge ss_if) begin
        if (strobe) begin
            t_q <= t;
        end
    end

    // arbiter must not withdraw a request it has not granted
    a_req_held: assert property (@(posedge ss_if) disable iff (rst)
        bus.req && !bus.gnt |=> bus.req)
        else $error("stack_ctl base %0d: req dropped without gnt", BASE);

    a_depth_max: assert property (@(posedge ss_if) disable iff (rst)
        count <= CW'(DEPTH))
        else $error("stack_ctl base %0d: depth %0d above %0d", BASE, count, DEPTH);

endmodule : stack_ctl

`default_nettype wire

// File: stack_arb.sv
// round-robin arbiter for the shared stack RAM
// grants one controller per cycle, a lone requester wins at once
`timescale 1ns/10ps
`default_nettype none

module stack_arb #(
    parameter int DSZ = eforth1_pkg::DSZ,        // word width
    parameter int AW  = 5                        // RAM address width
) (
    input  wire logic            ss_if,          // clock
    input  wire logic            rst,            // sync reset, active high
    mem_io.slv                   ds,             // data stack controller
    mem_io.slv                   rs,             // return stack controller
    output logic                 ram_en,
    output logic                 ram_we,
    output logic [AW-1:0]        ram_addr,
    output logic [DSZ-1:0]       ram_wdata,
    input  wire logic [DSZ-1:0]  ram_rdata
);

    eforth1_pkg::arb_state_e prio;               // who wins a tie
    logic ds_win;
    logic rs_win;

    assign ds_win = ds.req && (!rs.req || prio == eforth1_pkg::ARB_DS_FIRST);
    assign rs_win = rs.req && !ds_win;

    assign ds.gnt = ds_win;
    assign rs.gnt = rs_win;

    // both sides see the read word, each picks it up in its own read-wait
    assign ds.rdata = ram_rdata;
    assign rs.rdata = ram_rdata;

    // steer granted port onto the RAM
    always_comb begin
        ram_en    = ds_win || rs_win;
        ram_we    = 1'b0;
        ram_addr  = '0;
        ram_wdata = '0;
        if (ds_win) begin
            ram_we    = ds.we;
            ram_addr  = ds.addr;
            ram_wdata = ds.wdata;
        end else if (rs_win) begin
            ram_we    = rs.we;
            ram_addr  = rs.addr;
            ram_wdata = rs.wdata;
        end
    end

    // priority flips only when both asked
    always_ff @(posedge ss_if) begin
        if (rst) begin
            prio <= eforth1_pkg::ARB_DS_FIRST;
        end else if (ds.req && rs.req) begin
            prio <= ds_win ? eforth1_pkg::ARB_RS_FIRST : eforth1_pkg::ARB_DS_FIRST;
        end
    end

    // loser of a tie still asks and wins the next cycle
    a_ds_wait: assert property (@(posedge ss_if) disable iff (rst)
        ds.req && !ds.gnt |=> ds.gnt)
        else $error("stack_arb: data stack request waited more than one cycle");

    a_rs_wait: assert property (@(posedge ss_if) disable iff (rst)
        rs.req && !rs.gnt |=> rs.gnt)
        else $error("stack_arb: return stack request waited more than one cycle");

endmodule : stack_arb

`default_nettype wire

// File: stack_ram.sv
// single-port synchronous stack memory
// registered read, a write leaves the read register alone
`timescale 1ns/10ps
`default_nettype none

module stack_ram #(
    parameter int DSZ = eforth1_pkg::DSZ,        // word width
    parameter int AW  = 5                        // address width
) (
    input  wire logic            ss_if,          // clock
    input  wire logic            en,             // access this cycle
    input  wire logic            we,             // write, else read
    input  wire logic [AW-1:0]   addr,
    input  wire logic [DSZ-1:0]  wdata,
    output logic [DSZ-1:0]       rdata           // one cycle after a read
);

    logic [DSZ-1:0] mem [2**AW];                 // both stacks, ds low half, rs high

    always_ff @(posedge ss_if) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule : stack_ram

`default_nettype wire

// File: mem_io.sv
// memory request channel between one stack controller and the RAM arbiter
// req holds with stable we/addr/wdata until gnt, rdata follows a read by one cycle
`timescale 1ns/10ps
`default_nettype none

interface mem_io #(
    parameter int AW  = 5,                       // RAM address width
    parameter int DSZ = eforth1_pkg::DSZ         // word width
) ();
    logic           req;                         // access wanted this cycle
    logic           we;                          // write when high
    logic [AW-1:0]  addr;                        // RAM word address
    logic [DSZ-1:0] wdata;                       // word to write
    logic           gnt;                         // RAM does the access this cycle
    logic [DSZ-1:0] rdata;                       // read word, cycle after grant

    // controller side
    modport mst (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    // arbiter side
    modport slv (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface : mem_io

`default_nettype wire

// File: eforth1_pkg.sv
// eforth1 stack subsystem shared types
// stack operation codes, arbiter priority state and default word width
`default_nettype none

package eforth1_pkg;

    localparam int DSZ = 16;              // default stack word width

    // operation requested on a stack port
    typedef enum logic [1:0] {
        SS_NONE = 2'b00,                  // no-op, strobe ignored
        SS_PUSH = 2'b01,                  // push t onto stack
        SS_POP  = 2'b10                   // pop top into s
    } ss_op_e;

    // round-robin priority between the two stack controllers
    typedef enum logic {
        ARB_DS_FIRST = 1'b0,              // data stack wins a tie
        ARB_RS_FIRST = 1'b1               // return stack wins a tie
    } arb_state_e;

endpackage : eforth1_pkg

`default_nettype wire
